//--- aesTop.f
+incdir+src
src/aesPkg.sv
src/aesCoreIf.sv
src/aesSbox.sv
src/aesKeySchedule.sv
src/aesRoundEngine.sv
src/aesApbRegs.sv
src/aesSegDisplay.sv
src/aesTop.sv
verification/aesTop_sva.sv
verification/aesTopTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f aesTop.f --top-module aesTopTb -o simAesTop

simOut=$(./obj_dir/simAesTop)
echo "$simOut"
echo "$simOut" | grep -q "^NO ERRORS$"

//--- src/aesApbRegs.sv
`timescale 1ns/1ps
`include "aes_params.svh"

module aesApbRegs import aesPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  apbAddrT paddr,
    input  logic    psel,
    input  logic    penable,
    input  logic    pwrite,
    input  wordT    pwdata,
    output wordT    prdata,
    output logic    pready,
    output logic    pslverr,
    aesCoreIf.regs  core,
    output byteT    resultByte
);

    stateT      keyReg;
    stateT      blockReg;
    stateT      resultReg;
    logic       doneBit;
    logic       startPulse;
    logic       access;
    logic       err;
    logic       wrOk;
    logic       startAcc;
    logic       hitCtrl, hitStatus, hitKey, hitBlock, hitResult;
    apbAddrT    groupAddr;
    logic [6:0] wordLsb;

    assign access    = psel && penable;
    assign pready    = 1'b1; // zero wait states
    assign groupAddr = {paddr[`APB_ADDR_W-1:4], 4'h0};
    assign wordLsb   = {~paddr[3:2], 5'd0}; // word 0 sits at the top

    assign hitCtrl   = paddr == `REG_CTRL;
    assign hitStatus = paddr == `REG_STATUS;
    assign hitKey    = paddr[1:0] == 2'b00 && groupAddr == `REG_KEY;
    assign hitBlock  = paddr[1:0] == 2'b00 && groupAddr == `REG_BLOCK;
    assign hitResult = paddr[1:0] == 2'b00 && groupAddr == `REG_RESULT;

    always_comb begin
        err = 1'b0;
        if (!(hitCtrl || hitStatus || hitKey || hitBlock || hitResult))
            err = 1'b1;
        else if (pwrite && (hitStatus || hitResult))
            err = 1'b1; // read only
        else if (pwrite && core.busy && (hitCtrl || hitKey || hitBlock))
            err = 1'b1; // inputs frozen while running
    end

    assign pslverr  = access && err;
    assign wrOk     = access && pwrite && !err;
    assign startAcc = wrOk && hitCtrl && pwdata[0];

    always_comb begin
        prdata = '0;
        if (access && !pwrite && !err) begin
            if (hitStatus)
                prdata = {{(`APB_DATA_W-2){1'b0}}, doneBit, core.busy};
            else if (hitKey)
                prdata = keyReg[wordLsb +: 32];
            else if (hitBlock)
                prdata = blockReg[wordLsb +: 32];
            else if (hitResult)
                prdata = resultReg[wordLsb +: 32];
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            keyReg     <= '0;
            blockReg   <= '0;
            resultReg  <= '0;
            doneBit    <= 1'b0;
            startPulse <= 1'b0;
        end else begin
            startPulse <= startAcc;
            if (wrOk && hitKey)
                keyReg[wordLsb +: 32] <= pwdata;
            if (wrOk && hitBlock)
                blockReg[wordLsb +: 32] <= pwdata;
            if (core.done)
                resultReg <= core.result;
            if (startAcc)
                doneBit <= 1'b0;
            else if (core.done)
                doneBit <= 1'b1; // sticky until next start
        end
    end

    assign core.start = startPulse;
    assign core.key   = keyReg;
    assign core.block = blockReg;
    assign resultByte = resultReg[7:0];

endmodule

//--- src/aesCoreIf.sv
`timescale 1ns/1ps

interface aesCoreIf import aesPkg::*; ();

    logic  start;  // single cycle
    stateT key;
    stateT block;
    logic  busy;
    logic  done;   // single cycle
    stateT result;

    modport regs (
        output start, key, block,
        input  busy, done, result
    );

    modport core (
        input  start, key, block,
        output busy, done, result
    );

endinterface

//--- src/aesKeySchedule.sv
`timescale 1ns/1ps

module aesKeySchedule import aesPkg::*; (
    input  logic  clk,
    input  logic  rstN,
    input  logic  load,
    input  logic  step,
    input  stateT cipherKey,
    output stateT roundKey
);

    stateT keyReg;
    stateT baseKey;
    stateT nextKey;
    byteT  rcon;
    byteT  rconUse;
    wordT  rotW;
    wordT  subW;

    // load produces round key 1 straight from the cipher key
    assign baseKey = load ? cipherKey : keyReg;
    assign rconUse = load ? 8'h01 : rcon;
    assign rotW    = {baseKey[23:0], baseKey[31:24]};

    for (genvar i = 0; i < 4; i++) begin : gSubWord
        aesSbox uSbox (
            .in  (rotW[8*i +: 8]),
            .out (subW[8*i +: 8])
        );
    end

    assign nextKey[127:96] = baseKey[127:96] ^ subW ^ {rconUse, 24'h0};
    assign nextKey[95:64]  = baseKey[95:64] ^ nextKey[127:96];
    assign nextKey[63:32]  = baseKey[63:32] ^ nextKey[95:64];
    assign nextKey[31:0]   = baseKey[31:0] ^ nextKey[63:32];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN)
            rcon <= 8'h01;
        else if (load)
            rcon <= 8'h02;
        else if (step)
            rcon <= xtime(rcon);
    end

    always_ff @(posedge clk) begin
        if (load || step)
            keyReg <= nextKey;
    end

    assign roundKey = keyReg;

endmodule

//--- src/aesPkg.sv
`include "aes_params.svh"

package aesPkg;

    typedef logic [7:0]               byteT;
    typedef logic [`APB_DATA_W-1:0]   wordT;
    typedef logic [127:0]             stateT;
    typedef logic [3:0]               roundT;
    typedef logic [`APB_ADDR_W-1:0]   apbAddrT;
    typedef logic [6:0]               segT;  // active low, g down to a
    typedef logic [4*`SEG_DIGITS-1:0] bcdT;

    typedef enum logic {
        IDLE,
        RUN
    } engineStateE;

    // multiply by x in GF(2^8)
    function automatic byteT xtime(byteT b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

endpackage

//--- src/aesRoundEngine.sv
`timescale 1ns/1ps
`include "aes_params.svh"

module aesRoundEngine import aesPkg::*; (
    input logic    clk,
    input logic    rstN,
    aesCoreIf.core core
);

    engineStateE engState;
    roundT       round;
    stateT       stateReg;
    stateT       shifted;
    stateT       mixed;
    stateT       nextState;
    stateT       roundKey;
    byteT        subB [16];
    logic        loadKey;
    logic        lastRound;
    logic        doneQ;

    function automatic wordT mixColumn(wordT col);
        byteT b0, b1, b2, b3;
        byteT m0, m1, m2, m3;
        b0 = col[31:24];
        b1 = col[23:16];
        b2 = col[15:8];
        b3 = col[7:0];
        m0 = xtime(b0);
        m1 = xtime(b1);
        m2 = xtime(b2);
        m3 = xtime(b3);
        return {m0 ^ m1 ^ b1 ^ b2 ^ b3,
                b0 ^ m1 ^ m2 ^ b2 ^ b3,
                b0 ^ b1 ^ m2 ^ m3 ^ b3,
                m0 ^ b0 ^ b1 ^ b2 ^ m3};
    endfunction

    assign loadKey   = engState == IDLE && core.start;
    assign lastRound = round == roundT'(`AES_ROUNDS);

    aesKeySchedule uKeySched (
        .clk       (clk),
        .rstN      (rstN),
        .load      (loadKey),
        .step      (engState == RUN),
        .cipherKey (core.key),
        .roundKey  (roundKey)
    );

    // byte i is row i%4, column i/4
    for (genvar i = 0; i < 16; i++) begin : gSubShift
        aesSbox uSbox (
            .in  (stateReg[127-8*i -: 8]),
            .out (subB[i])
        );
        assign shifted[127-8*i -: 8] = subB[(i % 4) + 4 * (((i / 4) + (i % 4)) % 4)];
    end

    for (genvar c = 0; c < 4; c++) begin : gMix
        assign mixed[127-32*c -: 32] = mixColumn(shifted[127-32*c -: 32]);
    end

    assign nextState = (lastRound ? shifted : mixed) ^ roundKey; // no mix in round 10

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            engState <= IDLE;
            round    <= '0;
            doneQ    <= 1'b0;
        end else begin
            doneQ <= 1'b0;
            case (engState)
                IDLE: begin
                    if (core.start) begin
                        engState <= RUN;
                        round    <= roundT'(1);
                    end
                end
                RUN: begin
                    if (lastRound) begin
                        engState <= IDLE;
                        doneQ    <= 1'b1;
                    end else begin
                        round <= round + 1'b1;
                    end
                end
                default: engState <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (loadKey)
            stateReg <= core.block ^ core.key; // round 0
        else if (engState == RUN)
            stateReg <= nextState;
    end

    assign core.busy   = engState == RUN;
    assign core.done   = doneQ;
    assign core.result = stateReg;

endmodule

//--- src/aesSbox.sv
`timescale 1ns/1ps

module aesSbox import aesPkg::*; (
    input  byteT in,
    output byteT out
);

    // forward substitution, entry 0 leftmost
    localparam logic [0:255][7:0] sBoxTable = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    assign out = sBoxTable[in];

endmodule

//--- src/aesSegDisplay.sv
`timescale 1ns/1ps
`include "aes_params.svh"

module aesSegDisplay import aesPkg::*; (
    input  byteT                        value,
    output logic [`SEG_DIGITS*7-1:0]    segOut
);

    bcdT bcd;

    // shift-and-add-3
    always_comb begin
        bcd = '0;
        for (int i = 7; i >= 0; i--) begin
            for (int d = 0; d < `SEG_DIGITS; d++) begin
                if (bcd[4*d +: 4] >= 4'd5)
                    bcd[4*d +: 4] = bcd[4*d +: 4] + 4'd3;
            end
            bcd = {bcd[4*`SEG_DIGITS-2:0], value[i]};
        end
    end

    // hundreds digit ends up in the top bits
    for (genvar d = 0; d < `SEG_DIGITS; d++) begin : gDigit
        segT seg;

        always_comb begin
            case (bcd[4*d +: 4])
                4'd0:    seg = 7'b1000000;
                4'd1:    seg = 7'b1111001;
                4'd2:    seg = 7'b0100100;
                4'd3:    seg = 7'b0110000;
                4'd4:    seg = 7'b0011001;
                4'd5:    seg = 7'b0010010;
                4'd6:    seg = 7'b0000010;
                4'd7:    seg = 7'b1111000;
                4'd8:    seg = 7'b0000000;
                4'd9:    seg = 7'b0010000;
                default: seg = 7'b1111111; // blank
            endcase
        end

        assign segOut[7*d +: 7] = seg;
    end

endmodule

//--- src/aesTop.sv
`timescale 1ns/1ps

module aesTop import aesPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  apbAddrT     paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  wordT        pwdata,
    output wordT        prdata,
    output logic        pready,
    output logic        pslverr,
    output logic [20:0] segOut
);

    byteT resultByte;

    aesCoreIf coreBus ();

    aesApbRegs uRegs (
        .clk        (clk),
        .rstN       (rstN),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .core       (coreBus.regs),
        .resultByte (resultByte)
    );

    aesRoundEngine uEngine (
        .clk  (clk),
        .rstN (rstN),
        .core (coreBus.core)
    );

    aesSegDisplay uDisplay (
        .value  (resultByte),
        .segOut (segOut)
    );

endmodule

//--- src/aes_params.svh
`ifndef AES_PARAMS_SVH
`define AES_PARAMS_SVH

`define AES_ROUNDS  10
`define APB_ADDR_W  8
`define APB_DATA_W  32
`define REG_CTRL    8'h00
`define REG_STATUS  8'h04
`define REG_KEY     8'h10 // four words, word 0 is bits 127:96
`define REG_BLOCK   8'h20
`define REG_RESULT  8'h30
`define SEG_DIGITS  3

`endif

//--- verification/aesTopTb.sv
`timescale 1ns/1ps
`include "aes_params.svh"

module aesTopTb;

    localparam logic [127:0] key1 = 128'h000102030405060708090a0b0c0d0e0f;
    localparam logic [127:0] pt1  = 128'h00112233445566778899aabbccddeeff;
    localparam logic [127:0] ct1  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
    localparam logic [127:0] key2 = 128'h2b7e151628aed2a6abf7158809cf4f3c;
    localparam logic [127:0] pt2  = 128'h3243f6a8885a308d313198a2e0370734;
    localparam logic [127:0] ct2  = 128'h3925841d02dc09fbdc118597196a0b32;

    logic                   clk;
    logic                   rstN;
    logic [`APB_ADDR_W-1:0] paddr;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`APB_DATA_W-1:0] pwdata;
    logic [`APB_DATA_W-1:0] prdata;
    logic                   pready;
    logic                   pslverr;
    logic [20:0]            segOut;

    int          errors;
    int          testErrs;
    int          testsRun;
    int          testsFailed;
    int          maxGap;

    aesTop DUT (
        .clk     (clk),
        .rstN    (rstN),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .segOut  (segOut)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic checkValue(input string what, input logic [127:0] got,
                              input logic [127:0] exp);
        assert (got === exp)
        else begin
            $display("MISMATCH at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
            testErrs++;
        end
    endtask

    task automatic apbXfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic err);
        int waitCnt;
        repeat (int'($urandom_range(maxGap, 0))) @(posedge clk); // idle gap
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        waitCnt = 0;
        do begin
            @(posedge clk); // sees the access cycle values
            waitCnt++;
        end while (!pready && waitCnt < 8);
        if (!pready) begin
            $display("APB transfer to address %h never completed", addr);
            testErrs++;
        end
        rdata = prdata;
        err   = pslverr;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data, input logic expErr);
        logic [31:0] unused;
        logic        err;
        apbXfer(1'b1, addr, data, unused, err);
        checkValue($sformatf("pslverr of write to %h", addr), 128'(err), 128'(expErr));
    endtask

    task automatic apbRead(input logic [7:0] addr, output logic [31:0] data, input logic expErr);
        logic err;
        apbXfer(1'b0, addr, 32'h0, data, err);
        checkValue($sformatf("pslverr of read from %h", addr), 128'(err), 128'(expErr));
    endtask

    task automatic loadWords(input logic [7:0] base, input logic [127:0] value);
        for (int w = 0; w < 4; w++)
            apbWrite(base + 8'(4 * w), value[127-32*w -: 32], 1'b0); // word 0 is the top
    endtask

    task automatic readResult(output logic [127:0] value);
        logic [31:0] word;
        for (int w = 0; w < 4; w++) begin
            apbRead(`REG_RESULT + 8'(4 * w), word, 1'b0);
            value[127-32*w -: 32] = word;
        end
    endtask

    task automatic waitDone(output logic [31:0] status);
        int polls;
        polls  = 0;
        status = '0;
        while (!status[1] && polls < 40) begin
            apbRead(`REG_STATUS, status, 1'b0);
            polls++;
        end
        if (!status[1]) begin
            $display("timeout: done bit still clear after %0d status reads", polls);
            testErrs++;
        end
    endtask

    task automatic encrypt(input logic [127:0] key, input logic [127:0] pt,
                           output logic [127:0] ct);
        logic [31:0] status;
        loadWords(`REG_KEY, key);
        loadWords(`REG_BLOCK, pt);
        apbWrite(`REG_CTRL, 32'h1, 1'b0);
        waitDone(status);
        readResult(ct);
    endtask

    // active low, g down to a
    function automatic logic [6:0] digitPattern(input int d);
        case (d)
            0:       return 7'b1000000;
            1:       return 7'b1111001;
            2:       return 7'b0100100;
            3:       return 7'b0110000;
            4:       return 7'b0011001;
            5:       return 7'b0010010;
            6:       return 7'b0000010;
            7:       return 7'b1111000;
            8:       return 7'b0000000;
            9:       return 7'b0010000;
            default: return 7'b1111111;
        endcase
    endfunction

    function automatic logic [20:0] expectedSeg(input logic [7:0] v);
        int n;
        n = int'(v);
        return {digitPattern(n / 100), digitPattern((n / 10) % 10), digitPattern(n % 10)};
    endfunction

    task automatic finishTest(input string name);
        testsRun++;
        if (testErrs != 0)
            testsFailed++;
        $display("test %0d %s: %s", testsRun, name, (testErrs == 0) ? "passed" : "failed");
        errors  += testErrs;
        testErrs = 0;
    endtask

    initial begin
        logic [127:0] ct;
        logic [31:0]  rd;
        logic [31:0]  status;
        void'($urandom(32'h8cb7));
        errors      = 0;
        testErrs    = 0;
        testsRun    = 0;
        testsFailed = 0;
        maxGap      = 3;
        rstN        = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        repeat (16) @(posedge clk);
        rstN <= 1'b1;

        encrypt(key1, pt1, ct);
        checkValue("vector 1 ciphertext", ct, ct1);
        @(posedge clk);
        checkValue("display after vector 1", 128'(segOut), 128'(expectedSeg(ct1[7:0])));
        finishTest("vector 1 and display");

        encrypt(key2, pt2, ct);
        checkValue("vector 2 ciphertext", ct, ct2);
        @(posedge clk);
        checkValue("display after vector 2", 128'(segOut), 128'(expectedSeg(ct2[7:0])));
        finishTest("vector 2 and display");

        maxGap = 0; // stay inside the ten busy cycles
        apbWrite(`REG_CTRL, 32'h1, 1'b0);
        apbRead(`REG_STATUS, rd, 1'b0);
        checkValue("status right after start", 128'(rd), 128'h1);
        apbWrite(`REG_BLOCK, 32'hdeadbeef, 1'b1);
        apbWrite(`REG_CTRL, 32'h1, 1'b1);
        maxGap = 3;
        waitDone(status);
        checkValue("status after completion", 128'(status), 128'h2);
        readResult(ct);
        checkValue("repeat of vector 2", ct, ct2);
        apbWrite(`REG_CTRL, 32'h1, 1'b0);
        waitDone(status);
        readResult(ct);
        checkValue("vector 2 after refused writes", ct, ct2);
        finishTest("busy refusal");

        apbRead(8'h08, rd, 1'b1); // unmapped
        apbWrite(`REG_RESULT, 32'h12345678, 1'b1);
        apbRead(`REG_CTRL, rd, 1'b0);
        checkValue("ctrl readback", 128'(rd), 128'h0);
        readResult(ct);
        checkValue("result after refused write", ct, ct2);
        finishTest("address errors");

        $display("tests run %0d, tests failed %0d, failed checks %0d",
                 testsRun, testsFailed, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- verification/aesTop_sva.sv
`timescale 1ns/1ps

module aesTopSva (
    input logic        clk,
    input logic        rstN,
    input logic        psel,
    input logic        penable,
    input logic        pwrite,
    input logic        pslverr,
    input logic        start,
    input logic        busy,
    input logic        done,
    input logic [20:0] segOut
);

    localparam logic [20:0] segZeros = {3{7'b1000000}}; // 000 on all digits

    // every write is refused while running
    busyWriteErr: assert property (@(posedge clk) disable iff (!rstN)
        psel && penable && pwrite && busy |-> pslverr)
        else $error("write accepted while the engine was busy");

    // round 0 plus ten rounds
    doneLatency: assert property (@(posedge clk) disable iff (!rstN)
        start |-> ##11 done)
        else $error("done did not pulse 11 cycles after start");

    startWhenIdle: assert property (@(posedge clk) disable iff (!rstN)
        start |-> !busy)
        else $error("start accepted while the engine was busy");

    segAfterReset: assert property (@(posedge clk)
        $rose(rstN) |-> segOut == segZeros)
        else $error("display not showing 000 after reset");

endmodule

bind aesTop aesTopSva uSva (
    .clk     (clk),
    .rstN    (rstN),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pslverr (pslverr),
    .start   (coreBus.start),
    .busy    (coreBus.busy),
    .done    (coreBus.done),
    .segOut  (segOut)
);
